/* files.f */
hw/rvIsaPkg.sv
hw/frontEndPkg.sv
hw/instQueue.sv
hw/decoder.sv
hw/dispatcher.sv
hw/decodeTop.sv
tb/dispatch_assert.sv
tb/decodeTb.sv

/* hw/decodeTop.sv */
// Decode and dispatch front end.
// Instruction queue, decode stage and dispatcher in series.

`timescale 1ns/1ps
`default_nettype none

module decodeTop import frontEndPkg::*; #(
    parameter int QueueDepth = 8,
    parameter int AluSlots   = 4,
    parameter int MemSlots   = 2,
    parameter int BrSlots    = 2
) (
    input  wire              clk,
    input  wire              rstN,
    input  wire              fetchValid,
    input  wire fetchPacketT fetchPacket,
    output logic             fetchCredit,
    output decodedInstT      issueInst,
    output logic             aluValid,
    output logic             memValid,
    output logic             brValid,
    input  wire              aluCredit,
    input  wire              memCredit,
    input  wire              brCredit
);

    logic        headValid;
    fetchPacketT headPacket;
    logic        pop;
    logic        decValid;
    decodedInstT decInst;
    logic        decTake;

    instQueue #(.QueueDepth(QueueDepth)) uQueue (
        .clk, .rstN, .fetchValid, .fetchPacket, .fetchCredit,
        .headValid, .headPacket, .pop
    );

    decoder uDecoder (
        .clk, .rstN, .headValid, .headPacket, .pop,
        .decValid, .decInst, .decTake
    );

    dispatcher #(
        .AluSlots(AluSlots),
        .MemSlots(MemSlots),
        .BrSlots (BrSlots)
    ) uDispatcher (
        .clk, .rstN, .decValid, .decInst, .decTake, .issueInst,
        .aluValid, .memValid, .brValid, .aluCredit, .memCredit, .brCredit
    );

endmodule

`default_nettype wire

/* hw/decoder.sv */
// RV32I decode stage.
// Captures the queue head, resolves the operation and the format's
// immediate, and holds the record until the dispatcher takes it.

`timescale 1ns/1ps
`default_nettype none

module decoder import rvIsaPkg::*, frontEndPkg::*; (
    input  wire              clk,
    input  wire              rstN,
    input  wire              headValid,
    input  wire fetchPacketT headPacket,
    output logic             pop,
    output logic             decValid,
    output decodedInstT      decInst,
    input  wire              decTake
);

    logic [31:0] inst;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] immI, immS, immB, immU, immJ;
    opCodeE      op;
    opClassE     cls;
    logic [31:0] imm;
    logic        keepRs1, keepRs2, keepRd;
    decodedInstT nextInst;

    assign inst   = headPacket.inst;
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // Capture when the register is empty or is being emptied.
    assign pop = headValid && (!decValid || decTake);

    ////////////////////////////////////////////////////////////////////
    // Operation and format
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        op      = opIllegal;
        cls     = classNop;
        imm     = '0;
        keepRs1 = 1'b0;
        keepRs2 = 1'b0;
        keepRd  = 1'b0;
        case (inst[6:0])
            classLui: begin
                op = opLui; cls = classLui; imm = immU; keepRd = 1'b1;
            end
            classAuipc: begin
                op = opAuipc; cls = classAuipc; imm = immU; keepRd = 1'b1;
            end
            classJal: begin
                op = opJal; cls = classJal; imm = immJ; keepRd = 1'b1;
            end
            classJalr: begin
                cls = classJalr; imm = immI; keepRs1 = 1'b1; keepRd = 1'b1;
                if (funct3 == 3'b000) op = opJalr;
            end
            classBranch: begin
                cls = classBranch; imm = immB; keepRs1 = 1'b1; keepRs2 = 1'b1;
                case (funct3)
                    3'b000:  op = opBeq;
                    3'b001:  op = opBne;
                    3'b100:  op = opBlt;
                    3'b101:  op = opBge;
                    3'b110:  op = opBltu;
                    3'b111:  op = opBgeu;
                    default: op = opIllegal;
                endcase
            end
            classLoad: begin
                cls = classLoad; imm = immI; keepRs1 = 1'b1; keepRd = 1'b1;
                case (funct3)
                    3'b000:  op = opLb;
                    3'b001:  op = opLh;
                    3'b010:  op = opLw;
                    3'b100:  op = opLbu;
                    3'b101:  op = opLhu;
                    default: op = opIllegal;
                endcase
            end
            classStore: begin
                cls = classStore; imm = immS; keepRs1 = 1'b1; keepRs2 = 1'b1;
                case (funct3)
                    3'b000:  op = opSb;
                    3'b001:  op = opSh;
                    3'b010:  op = opSw;
                    default: op = opIllegal;
                endcase
            end
            classOpImm: begin
                cls = classOpImm; imm = immI; keepRs1 = 1'b1; keepRd = 1'b1;
                case (funct3)
                    3'b000: op = opAddi;
                    3'b010: op = opSlti;
                    3'b011: op = opSltiu;
                    3'b100: op = opXori;
                    3'b110: op = opOri;
                    3'b111: op = opAndi;
                    3'b001: op = (funct7 == Funct7Base) ? opSlli : opIllegal;
                    3'b101: begin
                        if (funct7 == Funct7Base) op = opSrli;
                        else if (funct7 == Funct7Alt) op = opSrai;
                    end
                    default: op = opIllegal;
                endcase
            end
            classOp: begin
                cls = classOp; keepRs1 = 1'b1; keepRs2 = 1'b1; keepRd = 1'b1;
                if (funct7 == Funct7Base) begin
                    case (funct3)
                        3'b000: op = opAdd;
                        3'b001: op = opSll;
                        3'b010: op = opSlt;
                        3'b011: op = opSltu;
                        3'b100: op = opXor;
                        3'b101: op = opSrl;
                        3'b110: op = opOr;
                        3'b111: op = opAnd;
                        default: op = opIllegal;
                    endcase
                end else if (funct7 == Funct7Alt && funct3 == 3'b000) begin
                    op = opSub;
                end else if (funct7 == Funct7Alt && funct3 == 3'b101) begin
                    op = opSra;
                end
            end
            // FENCE, SYSTEM and unknown opcodes stay illegal.
            default: op = opIllegal;
        endcase

        // Illegal words carry no operands and go to the ALU port.
        if (op == opIllegal) begin
            cls     = classNop;
            imm     = '0;
            keepRs1 = 1'b0;
            keepRs2 = 1'b0;
            keepRd  = 1'b0;
        end

        nextInst.opCode  = op;
        nextInst.opClass = cls;
        nextInst.rs1     = keepRs1 ? inst[19:15] : '0;
        nextInst.rs2     = keepRs2 ? inst[24:20] : '0;
        nextInst.rd      = keepRd ? inst[11:7] : '0;
        nextInst.pc      = headPacket.pc;
        nextInst.imm     = imm;
    end

    always_ff @(posedge clk) begin
        if (pop) decInst <= nextInst;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (pop) begin
            decValid <= 1'b1;
        end else if (decTake) begin
            decValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hw/dispatcher.sv */
// In-order dispatcher.
// Routes each decoded record to the ALU, memory or branch station,
// issuing only while that station has a free slot.

`timescale 1ns/1ps
`default_nettype none

module dispatcher import rvIsaPkg::*, frontEndPkg::*; #(
    parameter int AluSlots = 4,
    parameter int MemSlots = 2,
    parameter int BrSlots  = 2
) (
    input  wire              clk,
    input  wire              rstN,
    input  wire              decValid,
    input  wire decodedInstT decInst,
    output logic             decTake,
    output decodedInstT      issueInst,
    output logic             aluValid,
    output logic             memValid,
    output logic             brValid,
    input  wire              aluCredit,
    input  wire              memCredit,
    input  wire              brCredit
);

    localparam int MaxSlots = (AluSlots > MemSlots) ?
        ((AluSlots > BrSlots) ? AluSlots : BrSlots) :
        ((MemSlots > BrSlots) ? MemSlots : BrSlots);
    localparam int CntW = $clog2(MaxSlots + 1);

    // Indexed by issuePortE.
    localparam logic [2:0][CntW-1:0] SlotInit =
        {CntW'(BrSlots), CntW'(MemSlots), CntW'(AluSlots)};

    logic [2:0][CntW-1:0] credits;
    logic [2:0]           creditIn;
    logic [2:0]           issueHit;
    issuePortE            port;

    function automatic issuePortE portOf(opClassE cls);
        case (cls)
            classLoad, classStore:            portOf = portMem;
            classJal, classJalr, classBranch: portOf = portBr;
            default:                          portOf = portAlu;
        endcase
    endfunction

    assign port     = portOf(decInst.opClass);
    assign creditIn = {brCredit, memCredit, aluCredit};
    assign decTake  = decValid && (credits[port] != '0);
    assign issueHit = decTake ? (3'b001 << port) : 3'b000;

    always_ff @(posedge clk) begin
        if (decTake) issueInst <= decInst;
    end

    ////////////////////////////////////////////////////////////////////
    // Credit counters and port valids
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits                       <= SlotInit;
            {brValid, memValid, aluValid} <= 3'b000;
        end else begin
            {brValid, memValid, aluValid} <= issueHit;
            for (int i = 0; i < 3; i++) begin
                // Return and issue together cancel out.
                if (creditIn[i] && !issueHit[i]) begin
                    credits[i] <= credits[i] + 1'b1;
                end else if (issueHit[i] && !creditIn[i]) begin
                    credits[i] <= credits[i] - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/frontEndPkg.sv */
// Records passed between the front-end stages and the issue port
// encoding used by the dispatcher.

`default_nettype none

package frontEndPkg;

    import rvIsaPkg::*;

    // Fetched instruction with its address.
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
    } fetchPacketT;

    // Decoded record, one per instruction.
    typedef struct packed {
        opCodeE      opCode;
        opClassE     opClass;
        regNameT     rs1;
        regNameT     rs2;
        regNameT     rd;
        logic [31:0] pc;
        logic [31:0] imm;
    } decodedInstT;

    // Reservation station ports.
    typedef enum logic [1:0] {
        portAlu = 2'd0,
        portMem = 2'd1,
        portBr  = 2'd2
    } issuePortE;

endpackage

`default_nettype wire

/* hw/instQueue.sv */
// Instruction queue between fetch and decode.
// Circular buffer that hands one fetch credit back per consumed entry.

`timescale 1ns/1ps
`default_nettype none

module instQueue import frontEndPkg::*; #(
    parameter int QueueDepth = 8
) (
    input  wire              clk,
    input  wire              rstN,
    input  wire              fetchValid,
    input  wire fetchPacketT fetchPacket,
    output logic             fetchCredit,
    output logic             headValid,
    output fetchPacketT      headPacket,
    input  wire              pop
);

    localparam int PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CntW = $clog2(QueueDepth + 1);

    fetchPacketT     mem [QueueDepth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPop;

    function automatic logic [PtrW-1:0] nextPtr(logic [PtrW-1:0] ptr);
        nextPtr = (ptr == PtrW'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign doPop      = pop && headValid;
    assign headValid  = (count != '0);
    assign headPacket = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (fetchValid) begin
            mem[wrPtr] <= fetchPacket;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr       <= '0;
            rdPtr       <= '0;
            count       <= '0;
            fetchCredit <= 1'b0;
        end else begin
            if (fetchValid) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            case ({fetchValid, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit per freed entry.
            fetchCredit <= doPop;
        end
    end

endmodule

`default_nettype wire

/* hw/rvIsaPkg.sv */
// RV32I encoding definitions.
// Major opcode classes, the operations the front end decodes and the
// register name type.

`default_nettype none

package rvIsaPkg;

    // Major opcode field, inst[6:0].
    typedef enum logic [6:0] {
        classNop    = 7'b0000000,
        classLui    = 7'b0110111,
        classAuipc  = 7'b0010111,
        classJal    = 7'b1101111,
        classJalr   = 7'b1100111,
        classBranch = 7'b1100011,
        classLoad   = 7'b0000011,
        classStore  = 7'b0100011,
        classOpImm  = 7'b0010011,
        classOp     = 7'b0110011
    } opClassE;

    // Decoded operations, numbered in this order.
    typedef enum logic [5:0] {
        opNop,
        opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi,
        opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu,
        opXor, opSrl, opSra, opOr, opAnd,
        opIllegal
    } opCodeE;

    // Register 0 doubles as "no dependency".
    typedef logic [4:0] regNameT;

    // funct7 values that select between the two variants of an operation.
    localparam logic [6:0] Funct7Base = 7'b0000000;
    localparam logic [6:0] Funct7Alt  = 7'b0100000;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the front-end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module decodeTb -f files.f -o simDecode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simDecode > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi
exit 0

/* tb/decodeStim.txt */
# pc inst opCode port rs1 rs2 rd imm, all hex
# port 0 ALU, 1 MEM, 2 BR; opCode numbers follow the enum order
00001000 123452B7 01 0 00 00 05 12345000
00001004 FFFFF317 02 0 00 00 06 FFFFF000
00001008 001000EF 03 2 00 00 01 00000800
0000100C 00408067 04 2 01 00 00 00000004
00001010 FE208EE3 05 2 01 02 00 FFFFFFFC
00001014 00419463 06 2 03 04 00 00000008
00001018 0062C863 07 2 05 06 00 00000010
0000101C 0083F0E3 0A 2 07 08 00 00000800
00001020 FFF58503 0B 1 0B 00 0A FFFFFFFF
00001024 7FF6A603 0D 1 0D 00 0C 000007FF
00001028 00015083 0F 1 02 00 01 00000000
0000102C 003202A3 10 1 04 03 00 00000005
00001030 FE532C23 12 1 06 05 00 FFFFFFF8
00001034 00100093 13 0 00 00 01 00000001
00001038 FFF1B113 15 0 03 00 02 FFFFFFFF
0000103C 00329213 19 0 05 00 04 00000003
00001040 4043D313 1B 0 07 00 06 00000404
00001044 003100B3 1C 0 02 03 01 00000000
00001048 40628233 1D 0 05 06 04 00000000
0000104C 409453B3 23 0 08 09 07 00000000
00001050 00C5F533 25 0 0B 0C 0A 00000000
00001054 023100B3 26 0 00 00 00 00000000
00001058 0FF0000F 26 0 00 00 00 00000000
0000105C 00000073 26 0 00 00 00 00000000
00001060 0041A463 26 0 00 00 00 00000000
00001064 40329213 26 0 00 00 00 00000000

/* tb/decodeTb.sv */
// Testbench for the decode and dispatch front end.
// Models fetch and the three stations, and checks every issued record.

`timescale 1ns/1ps
`default_nettype none

module decodeTb import frontEndPkg::*; ();

    localparam int QueueDepth = 8;
    localparam int AluSlots   = 4;
    localparam int MemSlots   = 2;
    localparam int BrSlots    = 2;
    localparam int MaxInst    = 64;

    logic        clk;
    logic        rstN;
    logic        fetchValid;
    fetchPacketT fetchPacket;
    logic        fetchCredit;
    decodedInstT issueInst;
    logic        aluValid, memValid, brValid;
    logic        aluCredit, memCredit, brCredit;

    logic [31:0] stPc [MaxInst];
    logic [31:0] stInst [MaxInst];
    logic [31:0] stOp [MaxInst];
    logic [31:0] stPort [MaxInst];
    logic [31:0] stRs1 [MaxInst];
    logic [31:0] stRs2 [MaxInst];
    logic [31:0] stRd [MaxInst];
    logic [31:0] stImm [MaxInst];
    int          numInst;
    int          creds;
    int          creditsSeen;
    int          issueIdx;
    int          held [3];
    int          delay [3];
    int          issued [3];
    bit          stalled [3];
    int          slots [3];
    logic [31:0] rng;

    decodeTop #(
        .QueueDepth(QueueDepth),
        .AluSlots(AluSlots),
        .MemSlots(MemSlots),
        .BrSlots(BrSlots)
    ) u_dut (
        .clk, .rstN, .fetchValid, .fetchPacket, .fetchCredit, .issueInst,
        .aluValid, .memValid, .brValid, .aluCredit, .memCredit, .brCredit
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Illegal words carry the NOP class.
    function automatic logic [31:0] expectedClass(int idx);
        if (stOp[idx] == 32'(rvIsaPkg::opIllegal)) begin
            return 32'(rvIsaPkg::classNop);
        end
        return {25'b0, stInst[idx][6:0]};
    endfunction

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic timedOut(input string what);
        $display("Timeout while waiting for %s at time %0t", what, $time);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic loadStimulus();
        int    fd;
        string line;
        int    got;
        fd = $fopen("tb/decodeStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tb/decodeStim.txt");
            $display("=== FAIL ===");
            $fatal(1);
        end
        numInst = 0;
        while (!$feof(fd) && numInst < MaxInst) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 8 && line.getc(0) != 8'h23) begin
                got = $sscanf(line, "%h %h %h %h %h %h %h %h", stPc[numInst],
                    stInst[numInst], stOp[numInst], stPort[numInst], stRs1[numInst],
                    stRs2[numInst], stRd[numInst], stImm[numInst]);
                if (got == 8) numInst++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Issue monitor and fetch credit tracking
    ////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int p;
        if (rstN) begin
            creds = creds + (fetchCredit ? 1 : 0) - (fetchValid ? 1 : 0);
            if (fetchCredit) creditsSeen++;
            checkEq("fetch credits within depth", 32'(creds <= QueueDepth), 1);
            checkEq("port valids per cycle",
                32'($countones({brValid, memValid, aluValid}) <= 1), 1);
            if (aluValid || memValid || brValid) begin
                p = memValid ? 1 : (brValid ? 2 : 0);
                checkEq("issue count", 32'(issueIdx < numInst), 1);
                checkEq("port", 32'(p), stPort[issueIdx]);
                checkEq("opCode", 32'(issueInst.opCode), stOp[issueIdx]);
                checkEq("opClass", 32'(issueInst.opClass), expectedClass(issueIdx));
                checkEq("rs1", 32'(issueInst.rs1), stRs1[issueIdx]);
                checkEq("rs2", 32'(issueInst.rs2), stRs2[issueIdx]);
                checkEq("rd", 32'(issueInst.rd), stRd[issueIdx]);
                checkEq("pc", issueInst.pc, stPc[issueIdx]);
                checkEq("imm", issueInst.imm, stImm[issueIdx]);
                issueIdx++;
                issued[p]++;
                held[p]++;
                checkEq("slots held by station", 32'(held[p] <= slots[p]), 1);
                // One long stall per port.
                if (issued[p] == 2 && !stalled[p]) begin
                    stalled[p] = 1'b1;
                    delay[p]   = 30;
                end
            end
        end
    end

    // Station models return slots on the falling edge.
    always @(negedge clk) begin
        logic [2:0] crd;
        crd = 3'b000;
        if (rstN) begin
            for (int p = 0; p < 3; p++) begin
                if (held[p] > 0) begin
                    if (delay[p] == 0) begin
                        crd[p] = 1'b1;
                        held[p]--;
                        rng      = xorshift32(rng);
                        delay[p] = int'(rng % 4);
                    end else begin
                        delay[p]--;
                    end
                end
            end
        end
        aluCredit = crd[0];
        memCredit = crd[1];
        brCredit  = crd[2];
    end

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////

    initial begin
        int waitCnt;
        clk         = 1'b0;
        rstN        = 1'b0;
        fetchValid  = 1'b0;
        fetchPacket = '0;
        aluCredit   = 1'b0;
        memCredit   = 1'b0;
        brCredit    = 1'b0;
        creds       = QueueDepth;
        creditsSeen = 0;
        issueIdx    = 0;
        rng         = 32'd65;
        slots       = '{AluSlots, MemSlots, BrSlots};
        for (int p = 0; p < 3; p++) begin
            held[p]    = 0;
            delay[p]   = 0;
            issued[p]  = 0;
            stalled[p] = 1'b0;
        end
        loadStimulus();
        checkEq("stimulus lines read", 32'(numInst > 0), 1);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // Quiet outputs before the first push.
        repeat (4) begin
            @(negedge clk);
            checkEq("idle port valids", {29'b0, brValid, memValid, aluValid}, 0);
            checkEq("idle fetchCredit", 32'(fetchCredit), 0);
        end

        for (int i = 0; i < numInst; i++) begin
            waitCnt = 0;
            while (creds == 0) begin
                fetchValid = 1'b0;
                @(negedge clk);
                waitCnt++;
                if (waitCnt > 300) timedOut("a fetch credit");
            end
            fetchValid       = 1'b1;
            fetchPacket.inst = stInst[i];
            fetchPacket.pc   = stPc[i];
            @(negedge clk);
        end
        fetchValid = 1'b0;

        waitCnt = 0;
        while (issueIdx < numInst) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > 1000) timedOut("all records to issue");
        end

        waitCnt = 0;
        while (held[0] + held[1] + held[2] > 0 || creds != QueueDepth) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > 300) timedOut("stations and queue to drain");
        end
        repeat (3) @(negedge clk);

        checkEq("fetch credits returned", 32'(creditsSeen), 32'(numInst));
        checkEq("records issued", 32'(issueIdx), 32'(numInst));
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/dispatch_assert.sv */
// Dispatcher port checks.
// Bound into every dispatcher instance.

`timescale 1ns/1ps
`default_nettype none

module dispatchAssert #(
    parameter int CntW = 3
) (
    input wire                  clk,
    input wire                  rstN,
    input wire                  aluValid,
    input wire                  memValid,
    input wire                  brValid,
    input wire                  decTake,
    input wire [2:0][CntW-1:0]  credits
);

    logic [2:0] valids;
    logic [2:0] hasSlot;

    assign valids  = {brValid, memValid, aluValid};
    assign hasSlot = {credits[2] != '0, credits[1] != '0, credits[0] != '0};

    oneValid: assert property (@(posedge clk) $countones(valids) <= 1)
        else $error("more than one port valid");

    // A valid needs a free slot on its port when the record was taken.
    issueNeedsSlot: assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> ((valids & ~$past(hasSlot)) == 3'b000))
        else $error("issue on a port without credit");

    // Each take gives exactly one valid cycle.
    validOneCycle: assert property (@(posedge clk) disable iff (!rstN)
        $past(rstN) |-> ((valids != 3'b000) == $past(decTake)))
        else $error("port valid without a matching take");

    quietInReset: assert property (@(posedge clk) !rstN |-> (valids == 3'b000))
        else $error("port valid during reset");

endmodule

bind dispatcher dispatchAssert #(.CntW(CntW)) uAssert (
    .clk(clk),
    .rstN(rstN),
    .aluValid(aluValid),
    .memValid(memValid),
    .brValid(brValid),
    .decTake(decTake),
    .credits(credits)
);

`default_nettype wire
